// File: sources.f
+incdir+verif
rtl/tracker_pkg.sv
rtl/req_if.sv
rtl/index_extractor.sv
rtl/req_fifo.sv
rtl/index_counter_table.sv
rtl/access_tracker_top.sv
verif/tb_access_tracker.sv

// File: Makefile
# Verilator flow for the access tracker

TOP = tb_access_tracker

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps --top-module access_tracker_top \
		rtl/tracker_pkg.sv rtl/req_if.sv rtl/index_extractor.sv rtl/req_fifo.sv \
		rtl/index_counter_table.sv rtl/access_tracker_top.sv

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// row fields are name, ar valid, ar id, ar addr, aw valid, aw id, aw addr, stall and reset
// stall 0 keeps the running stall
// a negative stall draws a random one
task load_table;
	// one read and one write on fresh indexes
	add_row("rd_single", 1'b1, 16'h0011, 64'h1000_0001, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("wr_single", 1'b0, 16'h0000, 64'h0, 1'b1, 16'h0022, 64'h2000_0002, 0, 1'b0);
	// mixed directions on index 5 with other indexes in between
	add_row("idx5_rd", 1'b1, 16'h0031, 64'h5, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("idx5_wr", 1'b0, 16'h0000, 64'h0, 1'b1, 16'h0032, 64'h45, 0, 1'b0);
	add_row("other_idx", 1'b1, 16'h0033, 64'h6, 1'b1, 16'h0034, 64'h7, 0, 1'b0);
	add_row("idx5_rd2", 1'b1, 16'h0035, 64'h805, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("idx5_wr3", 1'b0, 16'h0000, 64'h0, 1'b1, 16'h0036, 64'h905, -1, 1'b0);
	// both channels valid together
	add_row("tie_0", 1'b1, 16'h0041, 64'h8, 1'b1, 16'h0051, 64'h9, 0, 1'b0);
	// a lone read hands the following ties to AW first
	add_row("tie_lead", 1'b1, 16'h0045, 64'h8, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("tie_1", 1'b1, 16'h0042, 64'h8, 1'b1, 16'h0052, 64'h9, -1, 1'b0);
	add_row("tie_2", 1'b1, 16'h0043, 64'h8, 1'b1, 16'h0053, 64'h9, 0, 1'b0);
	add_row("tie_3", 1'b1, 16'h0044, 64'h8, 1'b1, 16'h0054, 64'h9, -1, 1'b0);
	// requests keep coming during a long response stall until the readies drop
	add_row("stall_long", 1'b1, 16'h0061, 64'hc, 1'b1, 16'h0071, 64'hd, 30, 1'b0);
	add_row("stall_more0", 1'b1, 16'h0062, 64'hc, 1'b1, 16'h0072, 64'hd, 0, 1'b0);
	add_row("stall_more1", 1'b1, 16'h0063, 64'hc, 1'b1, 16'h0073, 64'hd, 0, 1'b0);
	add_row("stall_more2", 1'b1, 16'h0064, 64'hc, 1'b1, 16'h0074, 64'hd, 0, 1'b0);
	add_row("stall_more3", 1'b1, 16'h0065, 64'hc, 1'b1, 16'h0075, 64'hd, 0, 1'b0);
	// upper address bits do not split index 10
	add_row("alias_0", 1'b1, 16'h0081, 64'ha, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("alias_1", 1'b0, 16'h0000, 64'h0, 1'b1, 16'h0082, 64'h1_0000_001a, 0, 1'b0);
	add_row("alias_2", 1'b1, 16'h0083, 64'hffff_ffff_ffff_fffa,
		1'b1, 16'h0084, 64'h8000_0000_0000_0aaa, -1, 1'b0);
	// responses still held back when the reset hits
	add_row("pre_reset", 1'b1, 16'h0091, 64'h1, 1'b1, 16'h0092, 64'h5, 20, 1'b0);
	add_row("pre_reset_rd", 1'b1, 16'h0093, 64'h2, 1'b0, 16'h0000, 64'h0, 0, 1'b0); // AW next
	add_row("mid_reset", 1'b0, 16'h0000, 64'h0, 1'b0, 16'h0000, 64'h0, 0, 1'b1);
	// first tie after the reset goes to AR
	add_row("post_tie", 1'b1, 16'h00a3, 64'h1, 1'b1, 16'h00a4, 64'h5, 0, 1'b0);
	add_row("post_rd", 1'b1, 16'h00a1, 64'h1, 1'b0, 16'h0000, 64'h0, 0, 1'b0);
	add_row("post_wr", 1'b0, 16'h0000, 64'h0, 1'b1, 16'h00a2, 64'h5, -1, 1'b0);
endtask

`endif

// File: verif/tb_access_tracker.sv
`timescale 1ns/1ps

module tb_access_tracker;
	import tracker_pkg::*;

	typedef struct packed {
		logic                  ar_v;
		logic [ID_WIDTH-1:0]   ar_id;
		logic [ADDR_WIDTH-1:0] ar_addr;
		logic                  aw_v;
		logic [ID_WIDTH-1:0]   aw_id;
		logic [ADDR_WIDTH-1:0] aw_addr;
		int                    stall; // response-ready low cycles
		logic                  rst;   // row is a mid-run reset
	} row_t;

	typedef struct packed {
		logic                  rw;
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [CNT_WIDTH-1:0]  count;
		int                    row; // row that issued the request
	} expect_t;

	logic                  clk;
	logic                  rst_n;
	logic [ID_WIDTH-1:0]   arid_i;
	logic [ADDR_WIDTH-1:0] araddr_i;
	logic                  arvalid_i;
	logic                  arready_o;
	logic [ID_WIDTH-1:0]   awid_i;
	logic [ADDR_WIDTH-1:0] awaddr_i;
	logic                  awvalid_i;
	logic                  awready_o;
	logic                  resp_valid_o;
	logic                  resp_ready_i;
	logic                  resp_rw_o;
	logic [ID_WIDTH-1:0]   resp_id_o;
	logic [ADDR_WIDTH-1:0] resp_addr_o;
	logic [CNT_WIDTH-1:0]  resp_count_o;

	row_t                 rows [$];
	string                row_names [$];
	expect_t              exp_q [$]; // responses in acceptance order
	logic [CNT_WIDTH-1:0] model_cnt [NUM_INDEX];
	logic                 prefer_aw; // model of the round-robin flag
	logic                 in_reset;
	int                   stall_left;
	int                   block_run;
	int                   max_block;
	int                   errors;
	int                   checks;
	int                   limit;
	integer               seed;

	access_tracker_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.arid_i       (arid_i),
		.araddr_i     (araddr_i),
		.arvalid_i    (arvalid_i),
		.arready_o    (arready_o),
		.awid_i       (awid_i),
		.awaddr_i     (awaddr_i),
		.awvalid_i    (awvalid_i),
		.awready_o    (awready_o),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i),
		.resp_rw_o    (resp_rw_o),
		.resp_id_o    (resp_id_o),
		.resp_addr_o  (resp_addr_o),
		.resp_count_o (resp_count_o)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task check_value(input string test, input string field,
		input logic [63:0] expected, input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s %s: expected %0h, actual %0h", test, field, expected, actual);
		end
	endtask

	task add_row(input string name,
		input logic ar_v, input logic [ID_WIDTH-1:0] ar_id, input logic [ADDR_WIDTH-1:0] ar_addr,
		input logic aw_v, input logic [ID_WIDTH-1:0] aw_id, input logic [ADDR_WIDTH-1:0] aw_addr,
		input int stall, input logic rst);
		row_t row;
		row.ar_v    = ar_v;
		row.ar_id   = ar_id;
		row.ar_addr = ar_addr;
		row.aw_v    = aw_v;
		row.aw_id   = aw_id;
		row.aw_addr = aw_addr;
		row.stall   = stall;
		row.rst     = rst;
		rows.push_back(row);
		row_names.push_back(name);
	endtask

	`include "tb_vectors.svh"

	// expected count is the number of earlier accesses to the same index
	task expect_request(input logic rw, input logic [ID_WIDTH-1:0] id,
		input logic [ADDR_WIDTH-1:0] addr, input int row);
		expect_t                e;
		logic [INDEX_WIDTH-1:0] idx;
		idx     = addr[INDEX_WIDTH-1:0];
		e.rw    = rw;
		e.id    = id;
		e.addr  = addr;
		e.count = model_cnt[idx];
		e.row   = row;
		model_cnt[idx] = model_cnt[idx] + 1'b1;
		exp_q.push_back(e);
	endtask

	task check_response;
		expect_t e;
		if (exp_q.size() == 0) begin
			errors++;
			$display("response with id %h arrived while no request was outstanding", resp_id_o);
		end else begin
			e = exp_q.pop_front();
			check_value(row_names[e.row], "rw", 64'(e.rw), 64'(resp_rw_o));
			check_value(row_names[e.row], "id", 64'(e.id), 64'(resp_id_o));
			check_value(row_names[e.row], "addr", e.addr, resp_addr_o);
			check_value(row_names[e.row], "count", 64'(e.count), 64'(resp_count_o));
		end
	endtask

	task apply_reset(input int r);
		@(posedge clk);
		in_reset   = 1'b1;
		stall_left = 0;
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		exp_q.delete(); // anything in flight is gone
		for (int i = 0; i < NUM_INDEX; i++) begin
			model_cnt[i] = '0;
		end
		prefer_aw = 1'b0;
		check_value(row_names[r], "arready", 64'd1, 64'(arready_o));
		check_value(row_names[r], "awready", 64'd1, 64'(awready_o));
		@(posedge clk);
		in_reset = 1'b0;
	endtask

	task apply_row(input int r);
		logic take_ar;
		logic take_aw;
		if (rows[r].rst) begin
			apply_reset(r);
		end else begin
			@(posedge clk);
			if (rows[r].stall < 0) begin
				stall_left = ($random(seed) & 15) + 1;
			end else if (rows[r].stall > 0) begin
				stall_left = rows[r].stall;
			end
			@(negedge clk);
			arvalid_i = rows[r].ar_v;
			arid_i    = rows[r].ar_id;
			araddr_i  = rows[r].ar_addr;
			awvalid_i = rows[r].aw_v;
			awid_i    = rows[r].aw_id;
			awaddr_i  = rows[r].aw_addr;
			while (arvalid_i || awvalid_i) begin
				// readies only move on the rising edge, so they are settled here
				if (arvalid_i && arready_o && awvalid_i && awready_o) begin
					take_ar = !prefer_aw;
					take_aw = prefer_aw;
				end else begin
					take_ar = arvalid_i && arready_o;
					take_aw = awvalid_i && awready_o;
				end
				if (take_ar) begin
					expect_request(1'b0, arid_i, araddr_i, r);
					prefer_aw = 1'b1;
				end
				if (take_aw) begin
					expect_request(1'b1, awid_i, awaddr_i, r);
					prefer_aw = 1'b0;
				end
				if (!arready_o && !awready_o) begin
					block_run++;
				end else begin
					block_run = 0;
				end
				if (block_run > max_block) begin
					max_block = block_run;
				end
				@(negedge clk);
				if (take_ar) begin
					arvalid_i = 1'b0;
				end
				if (take_aw) begin
					awvalid_i = 1'b0;
				end
			end
		end
	endtask

	// response side, ready and transfer decided together on the falling edge
	always @(negedge clk) begin
		if (in_reset) begin
			resp_ready_i = 1'b1;
		end else begin
			if (stall_left > 0) begin
				resp_ready_i = 1'b0;
				stall_left   = stall_left - 1;
			end else begin
				resp_ready_i = 1'b1;
			end
			if (resp_valid_o && resp_ready_i) begin
				check_response();
			end
		end
	end

	initial begin
		@(negedge clk);
		limit = rows.size() * 40 + 200;
		repeat (limit) @(posedge clk);
		$display("timeout: %0d responses still outstanding after %0d cycles", exp_q.size(), limit);
		$display("errors: %0d, checks: %0d", errors, checks);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		seed         = 77;
		errors       = 0;
		checks       = 0;
		stall_left   = 0;
		block_run    = 0;
		max_block    = 0;
		prefer_aw    = 1'b0;
		in_reset     = 1'b1;
		rst_n        = 1'b0;
		arid_i       = '0;
		araddr_i     = '0;
		arvalid_i    = 1'b0;
		awid_i       = '0;
		awaddr_i     = '0;
		awvalid_i    = 1'b0;
		resp_ready_i = 1'b0;
		for (int i = 0; i < NUM_INDEX; i++) begin
			model_cnt[i] = '0;
		end
		load_table();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		in_reset = 1'b0;

		for (int r = 0; r < rows.size(); r++) begin
			apply_row(r);
		end
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (10) @(negedge clk); // catch extra responses
		check_value("stall_long", "ready_low_run", 64'd1, 64'(max_block > 4));

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/access_tracker_top.sv
`timescale 1ns/1ps

module access_tracker_top (
	input  logic                               clk,
	input  logic                               rst_n,

	input  logic [tracker_pkg::ID_WIDTH-1:0]   arid_i,
	input  logic [tracker_pkg::ADDR_WIDTH-1:0] araddr_i,
	input  logic                               arvalid_i,
	output logic                               arready_o,

	input  logic [tracker_pkg::ID_WIDTH-1:0]   awid_i,
	input  logic [tracker_pkg::ADDR_WIDTH-1:0] awaddr_i,
	input  logic                               awvalid_i,
	output logic                               awready_o,

	output logic                               resp_valid_o,
	input  logic                               resp_ready_i,
	output logic                               resp_rw_o,
	output logic [tracker_pkg::ID_WIDTH-1:0]   resp_id_o,
	output logic [tracker_pkg::ADDR_WIDTH-1:0] resp_addr_o,
	output logic [tracker_pkg::CNT_WIDTH-1:0]  resp_count_o
);
	import tracker_pkg::*;

	// queue head towards the counter table
	logic      deq_valid;
	req_desc_t deq_desc;
	logic      deq_pop;

	req_if push_link ();

	index_extractor u_extractor (
		.clk       (clk),
		.rst_n     (rst_n),
		.arid_i    (arid_i),
		.araddr_i  (araddr_i),
		.arvalid_i (arvalid_i),
		.arready_o (arready_o),
		.awid_i    (awid_i),
		.awaddr_i  (awaddr_i),
		.awvalid_i (awvalid_i),
		.awready_o (awready_o),
		.push_o    (push_link.producer)
	);

	req_fifo u_fifo (
		.clk         (clk),
		.rst_n       (rst_n),
		.push_i      (push_link.consumer),
		.deq_valid_o (deq_valid),
		.deq_desc_o  (deq_desc),
		.deq_pop_i   (deq_pop)
	);

	index_counter_table u_table (
		.clk          (clk),
		.rst_n        (rst_n),
		.deq_valid_i  (deq_valid),
		.deq_desc_i   (deq_desc),
		.deq_pop_o    (deq_pop),
		.resp_valid_o (resp_valid_o),
		.resp_rw_o    (resp_rw_o),
		.resp_id_o    (resp_id_o),
		.resp_addr_o  (resp_addr_o),
		.resp_count_o (resp_count_o),
		.resp_ready_i (resp_ready_i)
	);

endmodule

// File: rtl/index_counter_table.sv
`timescale 1ns/1ps

module index_counter_table (
	input  logic                               clk,
	input  logic                               rst_n,

	input  logic                               deq_valid_i,
	input  tracker_pkg::req_desc_t             deq_desc_i,
	output logic                               deq_pop_o,

	output logic                               resp_valid_o,
	output logic                               resp_rw_o,
	output logic [tracker_pkg::ID_WIDTH-1:0]   resp_id_o,
	output logic [tracker_pkg::ADDR_WIDTH-1:0] resp_addr_o,
	output logic [tracker_pkg::CNT_WIDTH-1:0]  resp_count_o,
	input  logic                               resp_ready_i
);
	import tracker_pkg::*;

	logic [CNT_WIDTH-1:0]   cnt_q [NUM_INDEX];
	logic [INDEX_WIDTH-1:0] head_idx;

	logic                   resp_valid_q;
	logic                   resp_rw_q;
	logic [ID_WIDTH-1:0]    resp_id_q;
	logic [ADDR_WIDTH-1:0]  resp_addr_q;
	logic [CNT_WIDTH-1:0]   resp_count_q;

	assign head_idx = deq_desc_i.addr[INDEX_WIDTH-1:0];

	// pop only when the response register is free or draining this cycle
	assign deq_pop_o = deq_valid_i && (!resp_valid_q || resp_ready_i);

	// read and write back of one counter happen on the same edge, so back to
	// back pops of one index see the updated value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_INDEX; i++) begin
				cnt_q[i] <= '0;
			end
		end else if (deq_pop_o) begin
			cnt_q[head_idx] <= cnt_q[head_idx] + 1'b1; // wraps
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid_q <= 1'b0;
		end else if (deq_pop_o) begin
			resp_valid_q <= 1'b1;
		end else if (resp_ready_i) begin
			resp_valid_q <= 1'b0;
		end
	end

	// record holds while stalled since no pop happens then
	always_ff @(posedge clk) begin
		if (deq_pop_o) begin
			resp_rw_q    <= deq_desc_i.rw;
			resp_id_q    <= deq_desc_i.id;
			resp_addr_q  <= deq_desc_i.addr;
			resp_count_q <= cnt_q[head_idx]; // accesses seen before this one
		end
	end

	assign resp_valid_o = resp_valid_q;
	assign resp_rw_o    = resp_rw_q;
	assign resp_id_o    = resp_id_q;
	assign resp_addr_o  = resp_addr_q;
	assign resp_count_o = resp_count_q;

endmodule

// File: rtl/req_fifo.sv
`timescale 1ns/1ps

module req_fifo (
	input  logic                   clk,
	input  logic                   rst_n,

	req_if.consumer                push_i,

	output logic                   deq_valid_o,
	output tracker_pkg::req_desc_t deq_desc_o,
	input  logic                   deq_pop_i
);
	import tracker_pkg::*;

	req_desc_t               mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0]    wr_ptr_q;
	logic [PTR_WIDTH-1:0]    rd_ptr_q;
	logic [CREDIT_WIDTH-1:0] count_q; // 0 to FIFO_DEPTH entries
	logic                    credit_q;
	logic                    do_pop;

	assign deq_valid_o = (count_q != '0);
	assign deq_desc_o  = mem[rd_ptr_q];
	assign do_pop      = deq_pop_i && deq_valid_o;

	// the producer's credits keep pushes from ever landing on a full queue
	always_ff @(posedge clk) begin
		if (push_i.push) begin
			mem[wr_ptr_q] <= push_i.desc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			credit_q <= 1'b0;
		end else begin
			if (push_i.push) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // power of two depth, wraps
			end
			if (do_pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			case ({push_i.push, do_pop})
				2'b10: begin
					count_q <= count_q + 1'b1;
				end
				2'b01: begin
					count_q <= count_q - 1'b1;
				end
				default: begin
					count_q <= count_q;
				end
			endcase
			credit_q <= do_pop; // credit goes back the cycle after the pop
		end
	end

	assign push_i.credit_ret = credit_q;

endmodule

// File: rtl/index_extractor.sv
`timescale 1ns/1ps

module index_extractor (
	input  logic                               clk,
	input  logic                               rst_n,

	input  logic [tracker_pkg::ID_WIDTH-1:0]   arid_i,
	input  logic [tracker_pkg::ADDR_WIDTH-1:0] araddr_i,
	input  logic                               arvalid_i,
	output logic                               arready_o,

	input  logic [tracker_pkg::ID_WIDTH-1:0]   awid_i,
	input  logic [tracker_pkg::ADDR_WIDTH-1:0] awaddr_i,
	input  logic                               awvalid_i,
	output logic                               awready_o,

	req_if.producer                            push_o
);
	import tracker_pkg::*;

	ext_state_t              state_q;
	ext_state_t              state_n;
	logic                    rr_q;      // 0 gives AR priority
	req_desc_t               desc_q;
	logic                    push_q;
	logic [CREDIT_WIDTH-1:0] credits_q; // free queue entries

	logic                    ar_hs;
	logic                    aw_hs;
	logic                    grant_ar;
	logic                    grant_aw;
	logic                    take_credit;

	// both channels open only while idle
	assign arready_o = (state_q == EXT_IDLE);
	assign awready_o = (state_q == EXT_IDLE);

	assign ar_hs = arvalid_i && arready_o;
	assign aw_hs = awvalid_i && awready_o;

	// round robin when both fire together
	assign grant_ar = ar_hs && (!aw_hs || !rr_q);
	assign grant_aw = aw_hs && (!ar_hs || rr_q);

	assign take_credit = ((state_q == EXT_RREQ) || (state_q == EXT_WREQ)) &&
		(credits_q != '0);

	always_comb begin
		state_n = state_q;
		case (state_q)
			EXT_IDLE: begin
				if (grant_ar) begin
					state_n = EXT_RREQ;
				end else if (grant_aw) begin
					state_n = EXT_WREQ;
				end
			end
			EXT_RREQ, EXT_WREQ: begin
				if (take_credit) begin // wait here until the queue has room
					state_n = EXT_PUSH;
				end
			end
			EXT_PUSH: begin
				state_n = EXT_IDLE;
			end
			default: begin
				state_n = EXT_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= EXT_IDLE;
			rr_q    <= 1'b0;
			push_q  <= 1'b0;
		end else begin
			state_q <= state_n;
			push_q  <= take_credit; // high for the single PUSH cycle
			if (grant_ar) begin
				rr_q <= 1'b1; // AW wins the next tie
			end else if (grant_aw) begin
				rr_q <= 1'b0;
			end
		end
	end

	// one credit per push, one back per credit_ret pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			credits_q <= CREDIT_WIDTH'(FIFO_DEPTH);
		end else if (take_credit && !push_o.credit_ret) begin
			credits_q <= credits_q - 1'b1;
		end else if (!take_credit && push_o.credit_ret) begin
			credits_q <= credits_q + 1'b1;
		end
	end

	// request fields are latched at the handshake
	always_ff @(posedge clk) begin
		if (grant_ar) begin
			desc_q.rw   <= 1'b0;
			desc_q.id   <= arid_i;
			desc_q.addr <= araddr_i;
		end else if (grant_aw) begin
			desc_q.rw   <= 1'b1;
			desc_q.id   <= awid_i;
			desc_q.addr <= awaddr_i; // write index comes from the write address
		end
	end

	assign push_o.push = push_q;
	assign push_o.desc = desc_q;

endmodule

// File: rtl/req_if.sv
`timescale 1ns/1ps

// descriptor push link, flow controlled by credits
interface req_if;
	import tracker_pkg::*;

	logic      push;       // one descriptor per pulse
	req_desc_t desc;
	logic      credit_ret; // one pulse per entry popped from the queue

	modport producer (
		output push,
		output desc,
		input  credit_ret
	);

	modport consumer (
		input  push,
		input  desc,
		output credit_ret
	);

endinterface

// File: rtl/tracker_pkg.sv
package tracker_pkg;

	localparam int ADDR_WIDTH   = 64;
	localparam int ID_WIDTH     = 16;
	localparam int INDEX_WIDTH  = 4;  // low address bits used as table index
	localparam int CNT_WIDTH    = 16; // access counters wrap
	localparam int FIFO_DEPTH   = 4;  // also the initial credit count
	localparam int CREDIT_WIDTH = 3;

	// derived sizes
	localparam int PTR_WIDTH    = $clog2(FIFO_DEPTH);
	localparam int NUM_INDEX    = 1 << INDEX_WIDTH;

	// one queued request, the index is addr[INDEX_WIDTH-1:0]
	typedef struct packed {
		logic                  rw; // 0 read, 1 write
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
	} req_desc_t;

	typedef enum logic [1:0] {
		EXT_IDLE,
		EXT_RREQ,
		EXT_WREQ,
		EXT_PUSH
	} ext_state_t;

endpackage
